/* chroni_top.f */
source/chroni_video_pkg.sv
source/chroni_regs_pkg.sv
source/ram_dp.sv
source/vram_bytewide.sv
source/chroni_regs.sv
source/text_fetch.sv
source/glyph_expander.sv
source/scan_out.sv
source/chroni_top.sv
tests/tb_clock.sv
tests/chroni_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f chroni_top.f \
   --top-module chroni_tb -o chroni_sim \
   && ./obj_dir/chroni_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

/* source/chroni_regs.sv */
`timescale 1ns/1ns

module chroni_regs
   import chroni_regs_pkg::*;
   import chroni_video_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  reg_addr_t  paddr,
   input  logic [7:0] pwdata,
   output logic [7:0] prdata,
   input  logic       render_end,
   input  logic       busy,
   output text_cfg_t  cfg,
   output vram_wr_t   vram_wr,
   output pal_wr_t    pal_wr,
   output rgb565_t    border,
   output logic       irq
);

   logic            wr_acc;
   vram_byte_addr_t vram_addr;
   logic [7:0]      pal_index;
   logic [7:0]      pal_lo;
   logic            pal_hi_next;    // low byte already held
   logic            irq_enable;
   logic            done;

   assign wr_acc = psel && penable && pwrite;
   assign irq    = irq_enable && done;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         cfg         <= '0;
         border      <= '0;
         vram_addr   <= '0;
         pal_index   <= '0;
         pal_lo      <= '0;
         pal_hi_next <= 1'b0;
         irq_enable  <= 1'b0;
         done        <= 1'b0;
         vram_wr     <= '0;
         pal_wr      <= '0;
      end else begin
         vram_wr.en <= 1'b0;
         pal_wr.en  <= 1'b0;
         if (wr_acc) begin
            case (paddr)
               reg_text_lo:   cfg.text_addr[7:0]  <= pwdata;
               reg_text_hi:   cfg.text_addr[15:8] <= pwdata;
               reg_attr_lo:   cfg.attr_addr[7:0]  <= pwdata;
               reg_attr_hi:   cfg.attr_addr[15:8] <= pwdata;
               reg_charset:   cfg.charset_base    <= pwdata;
               reg_border_lo: border[7:0]         <= pwdata;
               reg_border_hi: border[15:8]        <= pwdata;
               reg_vram_lo:   vram_addr[7:0]      <= pwdata;
               reg_vram_hi:   vram_addr[15:8]     <= pwdata;
               reg_vram_top:  vram_addr[16]       <= pwdata[0];
               reg_pal_index: begin
                  pal_index   <= pwdata;
                  pal_hi_next <= 1'b0;
               end
               reg_pal_data: begin
                  if (pal_hi_next) begin
                     pal_wr.en    <= 1'b1;
                     pal_wr.index <= pal_index;
                     pal_wr.color <= {pwdata, pal_lo};
                     pal_index    <= pal_index + 1'b1;
                     pal_hi_next  <= 1'b0;
                  end else begin
                     pal_lo      <= pwdata;
                     pal_hi_next <= 1'b1;
                  end
               end
               reg_vram_data: begin
                  // byte goes to both lanes, the enable picks one
                  vram_wr.en   <= 1'b1;
                  vram_wr.addr <= vram_addr[16:1];
                  vram_wr.be   <= vram_addr[0] ? 2'b10 : 2'b01;
                  vram_wr.data <= {pwdata, pwdata};
                  vram_addr    <= vram_addr + 1'b1;
               end
               reg_status: begin
                  irq_enable <= pwdata[2];
                  if (pwdata[6])
                     done <= 1'b0;    // write one to clear
               end
               default: ;
            endcase
         end
         if (render_end)
            done <= 1'b1;
      end
   end

   always_comb begin
      prdata = 8'h00;
      if (psel && !pwrite) begin
         case (paddr)
            reg_text_lo:   prdata = cfg.text_addr[7:0];
            reg_text_hi:   prdata = cfg.text_addr[15:8];
            reg_attr_lo:   prdata = cfg.attr_addr[7:0];
            reg_attr_hi:   prdata = cfg.attr_addr[15:8];
            reg_charset:   prdata = cfg.charset_base;
            reg_pal_index: prdata = pal_index;
            reg_vram_lo:   prdata = vram_addr[7:0];
            reg_vram_hi:   prdata = vram_addr[15:8];
            reg_vram_top:  prdata = {7'b0, vram_addr[16]};
            reg_status:    prdata = {busy, done, 3'b0, irq_enable, 2'b0};
            reg_border_lo: prdata = border[7:0];
            reg_border_hi: prdata = border[15:8];
            default:       prdata = 8'h00;
         endcase
      end
   end

   // an index write landing on a pending entry would store it at the wrong slot
   pal_index_clash: assert property (@(posedge sys_clk) disable iff (!reset_n)
      !(pal_wr.en && wr_acc && paddr == reg_pal_index))
      else $error("palette write collides with an index write");

endmodule

/* source/chroni_regs_pkg.sv */
package chroni_regs_pkg;
   import chroni_video_pkg::*;

   typedef logic [6:0] reg_addr_t;

   localparam reg_addr_t reg_text_lo   = 7'h00;
   localparam reg_addr_t reg_text_hi   = 7'h01;
   localparam reg_addr_t reg_charset   = 7'h02;
   localparam reg_addr_t reg_pal_index = 7'h04;
   localparam reg_addr_t reg_pal_data  = 7'h05;
   localparam reg_addr_t reg_vram_lo   = 7'h06;
   localparam reg_addr_t reg_vram_hi   = 7'h07;
   localparam reg_addr_t reg_vram_top  = 7'h08;   // bit 0 only
   localparam reg_addr_t reg_vram_data = 7'h09;
   localparam reg_addr_t reg_attr_lo   = 7'h0a;
   localparam reg_addr_t reg_attr_hi   = 7'h0b;
   localparam reg_addr_t reg_status    = 7'h12;
   localparam reg_addr_t reg_border_lo = 7'h1a;
   localparam reg_addr_t reg_border_hi = 7'h1b;

   typedef logic [16:0] vram_byte_addr_t;
   typedef logic [15:0] vram_word_addr_t;

   typedef struct packed {
      logic [15:0] text_addr;      // byte address of the char row
      logic [15:0] attr_addr;
      logic [7:0]  charset_base;
   } text_cfg_t;

   typedef struct packed {
      logic            en;
      vram_word_addr_t addr;
      logic [1:0]      be;         // [1] high lane, [0] low lane
      logic [15:0]     data;
   } vram_wr_t;

   typedef struct packed {
      logic       en;
      logic [7:0] index;
      rgb565_t    color;
   } pal_wr_t;
endpackage

/* source/chroni_top.sv */
`timescale 1ns/1ns

module chroni_top
   import chroni_regs_pkg::*;
   import chroni_video_pkg::*;
#(
   parameter int cols = 40
) (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  reg_addr_t              paddr,
   input  logic [7:0]             pwdata,
   output logic [7:0]             prdata,
   input  logic                   render_start,
   input  font_row_t              render_line,
   input  logic                   scan_req,
   input  logic [line_addr_w-1:0] scan_addr,
   output logic                   scan_valid,
   output rgb565_t                scan_rgb,
   output logic                   irq
);

   localparam int lb_depth = cols * glyph_w;
   localparam int lb_aw = $clog2(lb_depth);

   text_cfg_t       cfg;
   vram_wr_t        vram_wr;
   pal_wr_t         pal_wr;
   rgb565_t         border;
   logic            busy;
   logic            render_end;
   logic            line_end;
   vram_word_addr_t vram_rd_addr;
   logic [15:0]     vram_rd_data;
   glyph_t          glyph;
   logic            glyph_valid;
   logic            exp_busy;
   logic            lb_wr_en;
   logic [lb_aw-1:0] lb_wr_addr;
   logic [lb_aw-1:0] lb_rd_addr;
   pixel_idx_t      lb_wr_data;
   pixel_idx_t      lb_rd_data;
   pixel_idx_t      pal_rd_addr;
   rgb565_t         pal_rd_data;

   chroni_regs regs_inst (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .render_end (render_end),
      .busy       (busy),
      .cfg        (cfg),
      .vram_wr    (vram_wr),
      .pal_wr     (pal_wr),
      .border     (border),
      .irq        (irq)
   );

   vram_bytewide vram_inst (
      .sys_clk (sys_clk),
      .wr      (vram_wr),
      .rd_addr (vram_rd_addr),
      .rd_data (vram_rd_data)
   );

   ram_dp #(.entry_t(rgb565_t), .depth(pal_depth)) palette (
      .sys_clk (sys_clk),
      .wr_en   (pal_wr.en),
      .wr_addr (pal_wr.index),
      .wr_data (pal_wr.color),
      .rd_addr (pal_rd_addr),
      .rd_data (pal_rd_data)
   );

   ram_dp #(.entry_t(pixel_idx_t), .depth(lb_depth)) line_buffer (
      .sys_clk (sys_clk),
      .wr_en   (lb_wr_en),
      .wr_addr (lb_wr_addr),
      .wr_data (lb_wr_data),
      .rd_addr (lb_rd_addr),
      .rd_data (lb_rd_data)
   );

   text_fetch #(.cols(cols)) fetch_inst (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .render_start (render_start),
      .render_line  (render_line),
      .cfg          (cfg),
      .vram_addr    (vram_rd_addr),
      .vram_data    (vram_rd_data),
      .glyph        (glyph),
      .glyph_valid  (glyph_valid),
      .exp_busy     (exp_busy),
      .line_end     (line_end),
      .busy         (busy),
      .render_end   (render_end)
   );

   glyph_expander #(.cols(cols)) expander_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .glyph       (glyph),
      .glyph_valid (glyph_valid),
      .busy        (exp_busy),
      .lb_wr_en    (lb_wr_en),
      .lb_wr_addr  (lb_wr_addr),
      .lb_wr_data  (lb_wr_data),
      .line_end    (line_end)
   );

   scan_out #(.cols(cols)) scan_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .scan_req    (scan_req),
      .scan_addr   (scan_addr),
      .border      (border),
      .lb_rd_addr  (lb_rd_addr),
      .lb_rd_data  (lb_rd_data),
      .pal_rd_addr (pal_rd_addr),
      .pal_rd_data (pal_rd_data),
      .scan_valid  (scan_valid),
      .scan_rgb    (scan_rgb)
   );

endmodule

/* source/chroni_video_pkg.sv */
package chroni_video_pkg;
   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   typedef logic [7:0] pixel_idx_t;

   typedef struct packed {
      logic [7:0] font;
      logic [7:0] attr;    // high nibble background, low nibble foreground
      logic       last;    // final column of the line
   } glyph_t;

   typedef logic [2:0] font_row_t;

   localparam int glyph_w = 8;         // pixels per text column
   localparam int pal_depth = 256;
   localparam int line_addr_w = 11;    // scan-out address, wide enough for 256 columns
endpackage

/* source/glyph_expander.sv */
`timescale 1ns/1ns

module glyph_expander
   import chroni_video_pkg::*;
#(
   parameter int cols = 40,
   localparam int lb_aw = $clog2(cols * glyph_w)
) (
   input  logic             sys_clk,
   input  logic             reset_n,
   input  glyph_t           glyph,
   input  logic             glyph_valid,
   output logic             busy,
   output logic             lb_wr_en,
   output logic [lb_aw-1:0] lb_wr_addr,
   output pixel_idx_t       lb_wr_data,
   output logic             line_end
);

   localparam int col_w = $clog2(cols);
   localparam int k_w = $clog2(glyph_w);
   localparam logic [k_w-1:0] k_last = k_w'(glyph_w - 1);

   glyph_t           cur;
   logic [col_w-1:0] col;
   logic [k_w-1:0]   k;     // pixel within the column

   assign lb_wr_en   = busy;
   assign lb_wr_addr = lb_aw'(col * glyph_w) + lb_aw'(k);
   assign lb_wr_data = cur.font[k_last - k] ? {4'b0, cur.attr[3:0]} : {4'b0, cur.attr[7:4]};
   assign line_end   = busy && (k == k_last) && cur.last;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         busy <= 1'b0;
         col  <= '0;
         k    <= '0;
      end else if (!busy) begin
         if (glyph_valid) begin
            cur  <= glyph;
            k    <= '0;
            busy <= 1'b1;
         end
      end else begin
         k <= k + 1'b1;
         if (k == k_last) begin
            busy <= 1'b0;
            col  <= cur.last ? '0 : col + 1'b1;    // wrap for the next line
         end
      end
   end

endmodule

/* source/ram_dp.sv */
`timescale 1ns/1ns

module ram_dp #(
   parameter type entry_t = logic [7:0],
   parameter int depth = 256,
   localparam int aw = $clog2(depth)
) (
   input  logic          sys_clk,
   input  logic          wr_en,
   input  logic [aw-1:0] wr_addr,
   input  entry_t        wr_data,
   input  logic [aw-1:0] rd_addr,
   output entry_t        rd_data
);

   entry_t mem [depth];

   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      rd_data <= mem[rd_addr];    // one cycle read latency
   end

endmodule

/* source/scan_out.sv */
`timescale 1ns/1ns

module scan_out
   import chroni_video_pkg::*;
#(
   parameter int cols = 40,
   localparam int lb_aw = $clog2(cols * glyph_w)
) (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   scan_req,
   input  logic [line_addr_w-1:0] scan_addr,
   input  rgb565_t                border,
   output logic [lb_aw-1:0]       lb_rd_addr,
   input  pixel_idx_t             lb_rd_data,
   output pixel_idx_t             pal_rd_addr,
   input  rgb565_t                pal_rd_data,
   output logic                   scan_valid,
   output rgb565_t                scan_rgb
);

   localparam int line_px = cols * glyph_w;

   logic s1_valid;
   logic s1_border;
   logic s2_border;

   assign lb_rd_addr  = scan_addr[lb_aw-1:0];
   assign pal_rd_addr = lb_rd_data;     // stage two looks up the index
   assign scan_rgb    = s2_border ? border : pal_rd_data;

   always_ff @(posedge sys_clk) begin
      s1_border <= (scan_addr >= line_addr_w'(line_px));
      s2_border <= s1_border;
      if (!reset_n) begin
         s1_valid   <= 1'b0;
         scan_valid <= 1'b0;
      end else begin
         s1_valid   <= scan_req;
         scan_valid <= s1_valid;
      end
   end

endmodule

/* source/text_fetch.sv */
`timescale 1ns/1ns

module text_fetch
   import chroni_regs_pkg::*;
   import chroni_video_pkg::*;
#(
   parameter int cols = 40
) (
   input  logic            sys_clk,
   input  logic            reset_n,
   input  logic            render_start,
   input  font_row_t       render_line,
   input  text_cfg_t       cfg,
   output vram_word_addr_t vram_addr,
   input  logic [15:0]     vram_data,
   output glyph_t          glyph,
   output logic            glyph_valid,
   input  logic            exp_busy,
   input  logic            line_end,
   output logic            busy,
   output logic            render_end
);

   localparam int col_w = $clog2(cols);

   typedef enum logic [2:0] {
      s_idle,
      s_char,     // char address out
      s_attr,     // char byte back, attr address out
      s_font,     // attr byte back, font address out
      s_latch,    // font byte back
      s_hand,     // wait for the expander
      s_drain     // last glyph handed over
   } state_t;

   state_t          state;
   logic [col_w-1:0] col;
   logic [7:0]      char_q;
   font_row_t       line_q;
   vram_byte_addr_t byte_addr;
   logic            lane_q;
   logic [7:0]      rd_byte;

   always_comb begin
      case (state)
         s_attr:  byte_addr = {1'b0, cfg.attr_addr} + 17'(col);
         s_font:  byte_addr = {cfg.charset_base[6:0] + 7'(char_q[7]), char_q[6:0], line_q};
         default: byte_addr = {1'b0, cfg.text_addr} + 17'(col);
      endcase
   end

   assign vram_addr  = byte_addr[16:1];
   assign rd_byte    = lane_q ? vram_data[15:8] : vram_data[7:0];
   assign busy       = (state != s_idle);
   assign render_end = (state == s_drain) && line_end;

   always_ff @(posedge sys_clk) begin
      lane_q <= byte_addr[0];    // lane of the word coming back next cycle
      if (!reset_n) begin
         state       <= s_idle;
         col         <= '0;
         glyph_valid <= 1'b0;
      end else begin
         glyph_valid <= 1'b0;
         case (state)
            s_idle: begin
               if (render_start) begin
                  col    <= '0;
                  line_q <= render_line;
                  state  <= s_char;
               end
            end
            s_char: state <= s_attr;
            s_attr: begin
               char_q <= rd_byte;
               state  <= s_font;
            end
            s_font: begin
               glyph.attr <= rd_byte;
               state      <= s_latch;
            end
            s_latch: begin
               glyph.font <= rd_byte;
               glyph.last <= (col == col_w'(cols - 1));
               state      <= s_hand;
            end
            s_hand: begin
               if (!exp_busy) begin
                  glyph_valid <= 1'b1;
                  if (glyph.last) begin
                     state <= s_drain;
                  end else begin
                     col   <= col + 1'b1;
                     state <= s_char;
                  end
               end
            end
            s_drain: begin
               if (line_end)
                  state <= s_idle;
            end
            default: state <= s_idle;
         endcase
      end
   end

   glyph_no_overrun: assert property (@(posedge sys_clk) disable iff (!reset_n)
      glyph_valid |-> !exp_busy)
      else $error("glyph handed over while the expander is busy");

endmodule

/* source/vram_bytewide.sv */
`timescale 1ns/1ns

module vram_bytewide
   import chroni_regs_pkg::*;
(
   input  logic            sys_clk,
   input  vram_wr_t        wr,
   input  vram_word_addr_t rd_addr,
   output logic [15:0]     rd_data
);

   // one array per byte lane
   logic [7:0] mem_lo [65536];
   logic [7:0] mem_hi [65536];

   always_ff @(posedge sys_clk) begin
      if (wr.en && wr.be[0])
         mem_lo[wr.addr] <= wr.data[7:0];
      if (wr.en && wr.be[1])
         mem_hi[wr.addr] <= wr.data[15:8];
      rd_data <= {mem_hi[rd_addr], mem_lo[rd_addr]};
   end

endmodule

/* tests/chroni_tb.sv */
`timescale 1ns/1ns

module chroni_tb
   import chroni_regs_pkg::*;
   import chroni_video_pkg::*;
();

   localparam int cols = 40;
   localparam int line_px = cols * glyph_w;
   localparam int scan_span = 2 ** line_addr_w;

   logic                   sys_clk;
   logic                   reset_n;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   reg_addr_t              paddr;
   logic [7:0]             pwdata;
   logic [7:0]             prdata;
   logic                   render_start;
   font_row_t              render_line;
   logic                   scan_req;
   logic [line_addr_w-1:0] scan_addr;
   logic                   scan_valid;
   rgb565_t                scan_rgb;
   logic                   irq;

   logic [7:0]  vram_model [131072];    // byte addressed
   logic [15:0] pal_model [pal_depth];
   logic [15:0] exp_q [$];              // expected colours of requests in flight

   int          seed = 33;
   int          errors = 0;
   int          checks = 0;
   int          text_base;
   int          attr_base;
   logic [7:0]  charset_base;
   logic [15:0] border_color;
   int          cur_line;

   tb_clock #(.period(10), .reset_cycles(16)) clock_inst (
      .sys_clk (sys_clk),
      .reset_n (reset_n)
   );

   chroni_top #(.cols(cols)) chroni_top_inst (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .render_start (render_start),
      .render_line  (render_line),
      .scan_req     (scan_req),
      .scan_addr    (scan_addr),
      .scan_valid   (scan_valid),
      .scan_rgb     (scan_rgb),
      .irq          (irq)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR: %s at %0t", what, $time);
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic apb_write(input reg_addr_t addr, input logic [7:0] data);
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      penable = 1'b0;
      @(negedge sys_clk);
      penable = 1'b1;
      @(negedge sys_clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_read(input reg_addr_t addr, output logic [7:0] data);
      psel = 1'b1;
      pwrite = 1'b0;
      paddr = addr;
      penable = 1'b0;
      @(negedge sys_clk);
      penable = 1'b1;
      @(negedge sys_clk);
      data = prdata;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic load_vram(input int base, input int count, input logic [7:0] mask);
      logic [7:0] data;
      logic [7:0] rd;
      int stop;
      apb_write(reg_vram_lo, base[7:0]);
      apb_write(reg_vram_hi, base[15:8]);
      apb_write(reg_vram_top, {7'b0, base[16]});
      for (int i = 0; i < count; i++) begin
         data = $random(seed);
         data = data | mask;
         vram_model[base + i] = data;
         apb_write(reg_vram_data, data);
      end
      stop = base + count;    // address advances once per data byte
      apb_read(reg_vram_lo, rd);
      check_value("vram_lo", rd, stop[7:0]);
      apb_read(reg_vram_hi, rd);
      check_value("vram_hi", rd, stop[15:8]);
      apb_read(reg_vram_top, rd);
      check_value("vram_top", rd, {7'b0, stop[16]});
   endtask

   task automatic load_palette();
      logic [15:0] color;
      apb_write(reg_pal_index, 8'h00);    // one index write, then auto increment
      for (int i = 0; i < pal_depth; i++) begin
         color = $random(seed);
         pal_model[i] = color;
         apb_write(reg_pal_data, color[7:0]);
         apb_write(reg_pal_data, color[15:8]);
      end
   endtask

   task automatic set_text_cfg(input int text, input int attr, input logic [7:0] charset);
      logic [7:0] rd;
      text_base = text;
      attr_base = attr;
      charset_base = charset;
      apb_write(reg_text_lo, text[7:0]);
      apb_write(reg_text_hi, text[15:8]);
      apb_write(reg_attr_lo, attr[7:0]);
      apb_write(reg_attr_hi, attr[15:8]);
      apb_write(reg_charset, charset);
      apb_read(reg_text_lo, rd);
      check_value("text_lo", rd, text[7:0]);
      apb_read(reg_text_hi, rd);
      check_value("text_hi", rd, text[15:8]);
      apb_read(reg_attr_lo, rd);
      check_value("attr_lo", rd, attr[7:0]);
      apb_read(reg_attr_hi, rd);
      check_value("attr_hi", rd, attr[15:8]);
      apb_read(reg_charset, rd);
      check_value("charset", rd, charset);
   endtask

   task automatic start_render(input font_row_t line);
      logic [7:0] st;
      cur_line = line;
      render_line = line;
      render_start = 1'b1;
      @(negedge sys_clk);
      render_start = 1'b0;
      repeat (40) @(negedge sys_clk);    // a few columns already in the line buffer
      apb_read(reg_status, st);
      check_value("status.busy", st[7], 1'b1);
      // a restart here would refetch column 0 from another font row
      render_line = line + 1'b1;
      render_start = 1'b1;
      @(negedge sys_clk);
      render_start = 1'b0;
      render_line = line;
   endtask

   task automatic wait_render_done(output logic [7:0] st);
      int n;
      n = 0;
      st = 8'h00;
      while (!st[6] && n < 2000) begin
         apb_read(reg_status, st);
         n++;
      end
      if (!st[6])
         report_failure("render did not finish before the timeout");
   endtask

   function automatic logic [15:0] expected_pixel(input int x, input int line);
      int col;
      int k;
      int font_addr;
      logic [7:0] ch;
      logic [7:0] at;
      logic [7:0] fb;
      logic [3:0] idx;
      if (x >= line_px)
         return border_color;
      col = x / glyph_w;
      k = x % glyph_w;
      ch = vram_model[text_base + col];
      at = vram_model[attr_base + col];
      // char bit 7 selects the next 1K font bank, bank number wraps in 7 bits
      font_addr = (((charset_base % 128) + ch[7]) % 128) * 1024 + (ch % 128) * 8 + line;
      fb = vram_model[font_addr];
      idx = fb[7 - k] ? at[3:0] : at[7:4];    // set bit is foreground
      return pal_model[idx];
   endfunction

   task automatic scan_pixel(input int x);
      scan_req = 1'b1;
      scan_addr = x[line_addr_w-1:0];
      exp_q.push_back(expected_pixel(x, cur_line));
      @(negedge sys_clk);
   endtask

   task automatic scan_line();
      for (int x = 0; x < line_px; x++)
         scan_pixel(x);
      scan_req = 1'b0;
   endtask

   task automatic wait_scan_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 50) begin
         @(negedge sys_clk);
         n++;
      end
      if (exp_q.size() != 0)
         report_failure("scan results still missing after the timeout");
   endtask

   // outputs settle well before the falling edge
   always @(negedge sys_clk) begin
      logic [15:0] want;
      if (reset_n === 1'b1 && scan_valid) begin
         if (exp_q.size() == 0) begin
            report_failure("scan_valid seen with no request pending");
         end else begin
            want = exp_q.pop_front();
            check_value("scan_rgb", scan_rgb, want);
         end
      end
   end

   initial begin
      int n;
      int r;
      logic [7:0] rd;
      logic [7:0] st;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = 8'h00;
      render_start = 1'b0;
      render_line = '0;
      scan_req = 1'b0;
      scan_addr = '0;
      cur_line = 0;
      border_color = 16'ha5c3;
      n = 0;
      while (reset_n !== 1'b1 && n < 100) begin
         @(negedge sys_clk);
         n++;
      end
      if (reset_n !== 1'b1)
         report_failure("reset was never released");
      check_value("irq", irq, 1'b0);

      set_text_cfg(32'h1000, 32'h2000, 8'h10);
      apb_write(reg_border_lo, border_color[7:0]);
      apb_write(reg_border_hi, border_color[15:8]);
      apb_read(reg_border_lo, rd);
      check_value("border_lo", rd, border_color[7:0]);
      apb_read(reg_border_hi, rd);
      check_value("border_hi", rd, border_color[15:8]);

      load_vram(32'h1000, cols, 8'h00);       // characters
      load_vram(32'h2000, cols, 8'h00);       // attributes
      load_vram(32'h4000, 2048, 8'h00);       // font banks 0x10 and 0x11
      load_palette();

      // first line, irq disabled
      start_render(3'd3);
      wait_render_done(st);
      check_value("status.busy", st[7], 1'b0);
      check_value("status.done", st[6], 1'b1);
      check_value("irq", irq, 1'b0);
      scan_line();
      wait_scan_drain();

      // border addresses mixed with live pixels, back to back
      scan_pixel(line_px);
      scan_pixel(line_px - 1);
      scan_pixel(scan_span - 1);
      scan_pixel(0);
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         r = r & 32'h7fffffff;
         if (i % 2)
            scan_pixel(line_px + r % (scan_span - line_px));
         else
            scan_pixel(r % line_px);
      end
      scan_req = 1'b0;
      wait_scan_drain();

      apb_write(reg_status, 8'h04);
      check_value("irq", irq, 1'b1);
      apb_write(reg_status, 8'h44);    // clear done, keep irq enabled
      check_value("irq", irq, 1'b0);
      apb_read(reg_status, rd);
      check_value("status", rd, 8'h04);

      // second line uses the upper half of the font through char bit 7
      set_text_cfg(32'h1800, 32'h2000, 8'h0f);
      load_vram(32'h1800, cols, 8'h80);
      start_render(3'd5);
      wait_render_done(st);
      check_value("status.done", st[6], 1'b1);
      check_value("irq", irq, 1'b1);
      scan_line();
      wait_scan_drain();
      apb_write(reg_status, 8'h40);
      check_value("irq", irq, 1'b0);
      apb_read(reg_status, rd);
      check_value("status", rd, 8'h00);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
   parameter int period = 10,
   parameter int reset_cycles = 16
) (
   output logic sys_clk,
   output logic reset_n
);

   initial begin
      sys_clk = 1'b0;
      forever #(period / 2) sys_clk = ~sys_clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (reset_cycles) @(posedge sys_clk);
      @(negedge sys_clk);
      reset_n = 1'b1;    // released on a falling edge like all other inputs
   end

endmodule
